// ==== source/rv_serial_pkg.sv ====
`default_nettype none

package rv_serial_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   // Bit position within a word, LSB first
   typedef logic [4:0]      cnt_t;

   typedef logic [1:0]      alu_sel_t;

   localparam alu_sel_t ALU_ADD = 2'd0;
   localparam alu_sel_t ALU_XOR = 2'd1;
   localparam alu_sel_t ALU_OR  = 2'd2;
   localparam alu_sel_t ALU_AND = 2'd3;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_EXEC,
      ST_STORE
   } state_e;

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

endpackage

`default_nettype wire

// ==== source/core_if.sv ====
`default_nettype none

// Bit counter from the state machine to the serial units
interface cnt_if;
   import rv_serial_pkg::*;

   logic cnt_en;
   cnt_t cnt_idx;
   logic cnt0;
   logic cnt_done;

   modport state (output cnt_en, cnt_idx, cnt0, cnt_done);
   modport sink  (input  cnt_en, cnt_idx, cnt0, cnt_done);
endinterface

// Decoded instruction controls
interface dec_if;
   import rv_serial_pkg::*;

   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   logic      imm;
   logic      alu_sub;
   alu_sel_t  alu_sel;
   logic      use_imm;
   logic      is_lui;
   logic      rd_wen;
   logic      store_op;

   modport dec  (output rs1_addr, rs2_addr, rd_addr, imm, alu_sub, alu_sel,
                 use_imm, is_lui, rd_wen, store_op);
   modport user (input  rs1_addr, rs2_addr, rd_addr, imm, alu_sub, alu_sel,
                 use_imm, is_lui, rd_wen, store_op);
endinterface

`default_nettype wire

// ==== source/core_state.sv ====
`default_nettype none

module core_state (
   input  wire  clk,
   input  wire  i_rst_n,
   input  wire  i_ibus_ack,
   input  wire  i_dbus_ack,
   dec_if.user  dec,
   cnt_if.state cnt,
   output logic o_ibus_cyc,
   output logic o_dbus_cyc
);
   import rv_serial_pkg::*;

   state_e state_q;
   cnt_t   cnt_q;
   logic   exec;

   assign exec = (state_q == ST_EXEC);

   assign cnt.cnt_en   = exec;
   assign cnt.cnt_idx  = cnt_q;
   assign cnt.cnt0     = exec && (cnt_q == '0);
   assign cnt.cnt_done = exec && (cnt_q == cnt_t'(XLEN - 1));

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q    <= ST_FETCH;
         cnt_q      <= '0;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         case (state_q)
            ST_FETCH: begin
               if (o_ibus_cyc && i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  state_q    <= ST_EXEC;
               end else begin
                  o_ibus_cyc <= 1'b1;
               end
            end
            ST_EXEC: begin
               // Wraps back to zero after bit 31
               cnt_q <= cnt_q + cnt_t'(1);
               if (cnt.cnt_done) begin
                  if (dec.store_op) begin
                     state_q    <= ST_STORE;
                     o_dbus_cyc <= 1'b1;
                  end else begin
                     state_q <= ST_FETCH;
                  end
               end
            end
            ST_STORE: begin
               if (i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  state_q    <= ST_FETCH;
               end
            end
            default: state_q <= ST_FETCH;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/instr_decode.sv ====
`default_nettype none

module instr_decode (
   input  wire                  clk,
   input  wire                  i_rst_n,
   input  wire rv_serial_pkg::word_t i_ibus_rdt,
   input  wire                  i_ibus_ack,
   cnt_if.sink                  cnt,
   dec_if.dec                   dec
);
   import rv_serial_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7_ok;
   logic       add_f3;
   logic       bool_f3;
   logic       op_imm_ok;
   logic       op_ok;
   logic       lui;
   logic       store;
   alu_sel_t   sel;
   word_t      imm_val;
   word_t      imm_q;

   assign opcode = i_ibus_rdt[6:0];
   assign funct3 = i_ibus_rdt[14:12];

   // Only funct7 of 0000000 or 0100000 is an R-type we handle
   assign funct7_ok = !i_ibus_rdt[31] && (i_ibus_rdt[29:25] == '0);
   assign add_f3    = (funct3 == 3'b000);
   assign bool_f3   = (funct3 == 3'b100) || (funct3 == 3'b110) || (funct3 == 3'b111);

   assign op_imm_ok = (opcode == OPC_OP_IMM) && (add_f3 || bool_f3);
   assign op_ok     = (opcode == OPC_OP) && funct7_ok &&
                      (add_f3 || (bool_f3 && !i_ibus_rdt[30]));
   assign lui       = (opcode == OPC_LUI);
   assign store     = (opcode == OPC_STORE) && (funct3 == 3'b010);

   always_comb begin
      case (funct3)
         3'b100:  sel = ALU_XOR;
         3'b110:  sel = ALU_OR;
         3'b111:  sel = ALU_AND;
         default: sel = ALU_ADD;
      endcase
   end

   always_comb begin
      if (lui) begin
         imm_val = {i_ibus_rdt[31:12], 12'b0};
      end else if (opcode == OPC_STORE) begin
         imm_val = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:25], i_ibus_rdt[11:7]};
      end else begin
         imm_val = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         dec.rd_wen   <= 1'b0;
         dec.store_op <= 1'b0;
         dec.alu_sub  <= 1'b0;
         dec.alu_sel  <= ALU_ADD;
         dec.use_imm  <= 1'b0;
         dec.is_lui   <= 1'b0;
         dec.rs1_addr <= '0;
         dec.rs2_addr <= '0;
         dec.rd_addr  <= '0;
      end else if (i_ibus_ack) begin
         // Anything unsupported ends up with no write and no store
         dec.rd_wen   <= op_imm_ok || op_ok || lui;
         dec.store_op <= store;
         dec.alu_sub  <= op_ok && add_f3 && i_ibus_rdt[30];
         dec.alu_sel  <= sel;
         dec.use_imm  <= (opcode != OPC_OP);
         dec.is_lui   <= lui;
         dec.rs1_addr <= i_ibus_rdt[19:15];
         dec.rs2_addr <= i_ibus_rdt[24:20];
         dec.rd_addr  <= i_ibus_rdt[11:7];
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= imm_val;
      end else if (cnt.cnt_en) begin
         imm_q <= {1'b0, imm_q[XLEN-1:1]};
      end
   end

   assign dec.imm = imm_q[0];

endmodule

`default_nettype wire

// ==== source/serial_regfile.sv ====
`default_nettype none

module serial_regfile (
   input  wire  clk,
   input  wire  i_rst_n,
   input  wire  i_rd_bit,
   cnt_if.sink  cnt,
   dec_if.user  dec,
   output logic o_rs1_bit,
   output logic o_rs2_bit
);
   import rv_serial_pkg::*;

   word_t regs [0:31];
   logic  wen;

   // No writes while reset is held, x0 is never written
   assign wen = i_rst_n && cnt.cnt_en && dec.rd_wen && (dec.rd_addr != '0);

   always_ff @(posedge clk) begin
      if (wen) begin
         regs[dec.rd_addr][cnt.cnt_idx] <= i_rd_bit;
      end
   end

   // Old bit is read before the write of the same position lands
   assign o_rs1_bit = (dec.rs1_addr != '0) && regs[dec.rs1_addr][cnt.cnt_idx];
   assign o_rs2_bit = (dec.rs2_addr != '0) && regs[dec.rs2_addr][cnt.cnt_idx];

endmodule

`default_nettype wire

// ==== source/serial_alu.sv ====
`default_nettype none

module serial_alu (
   input  wire  clk,
   input  wire  i_rst_n,
   input  wire  i_rs1_bit,
   input  wire  i_rs2_bit,
   cnt_if.sink  cnt,
   dec_if.user  dec,
   output logic o_rd_bit
);
   import rv_serial_pkg::*;

   logic op_b;
   logic op_b_add;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic carry_next;

   assign op_b     = dec.use_imm ? dec.imm : i_rs2_bit;
   // Subtract as a + ~b + 1
   assign op_b_add = op_b ^ dec.alu_sub;
   assign carry_in = cnt.cnt0 ? dec.alu_sub : carry_q;

   assign sum        = i_rs1_bit ^ op_b_add ^ carry_in;
   assign carry_next = (i_rs1_bit & op_b_add) | (i_rs1_bit & carry_in) |
                       (op_b_add & carry_in);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (cnt.cnt_en) begin
         carry_q <= carry_next;
      end
   end

   always_comb begin
      if (dec.is_lui) begin
         o_rd_bit = dec.imm;
      end else begin
         case (dec.alu_sel)
            ALU_XOR: o_rd_bit = i_rs1_bit ^ op_b;
            ALU_OR:  o_rd_bit = i_rs1_bit | op_b;
            ALU_AND: o_rd_bit = i_rs1_bit & op_b;
            default: o_rd_bit = sum;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/store_unit.sv ====
`default_nettype none

module store_unit (
   input  wire                  clk,
   input  wire                  i_rst_n,
   input  wire                  i_rs1_bit,
   input  wire                  i_rs2_bit,
   cnt_if.sink                  cnt,
   dec_if.user                  dec,
   output rv_serial_pkg::word_t o_dbus_adr,
   output rv_serial_pkg::word_t o_dbus_dat
);
   import rv_serial_pkg::*;

   word_t adr_q;
   word_t dat_q;
   logic  shift_en;
   logic  carry_q;
   logic  carry_in;
   logic  adr_bit;
   logic  carry_next;

   // Holds once execute ends so the bus sees a stable word
   assign shift_en = cnt.cnt_en && dec.store_op;

   // rs1 + S-immediate
   assign carry_in   = cnt.cnt0 ? 1'b0 : carry_q;
   assign adr_bit    = i_rs1_bit ^ dec.imm ^ carry_in;
   assign carry_next = (i_rs1_bit & dec.imm) | (i_rs1_bit & carry_in) |
                       (dec.imm & carry_in);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (shift_en) begin
         carry_q <= carry_next;
      end
   end

   // Bits enter at the top, LSB lands at bit 0 after 32 shifts
   always_ff @(posedge clk) begin
      if (shift_en) begin
         adr_q <= {adr_bit, adr_q[XLEN-1:1]};
         dat_q <= {i_rs2_bit, dat_q[XLEN-1:1]};
      end
   end

   assign o_dbus_adr = adr_q;
   assign o_dbus_dat = dat_q;

endmodule

`default_nettype wire

// ==== source/pc_ctrl.sv ====
`default_nettype none

module pc_ctrl #(
   parameter rv_serial_pkg::word_t RESET_PC = '0
) (
   input  wire                  clk,
   input  wire                  i_rst_n,
   cnt_if.sink                  cnt,
   output rv_serial_pkg::word_t o_pc
);
   import rv_serial_pkg::*;

   logic inc_bit;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic carry_next;

   // Plus four is a single set bit at position 2
   assign inc_bit    = (cnt.cnt_idx == cnt_t'(2));
   assign carry_in   = cnt.cnt0 ? 1'b0 : carry_q;
   assign sum        = o_pc[0] ^ inc_bit ^ carry_in;
   assign carry_next = (o_pc[0] & inc_bit) | (o_pc[0] & carry_in) | (inc_bit & carry_in);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_pc    <= RESET_PC;
         carry_q <= 1'b0;
      end else if (cnt.cnt_en) begin
         o_pc    <= {sum, o_pc[XLEN-1:1]};
         carry_q <= carry_next;
      end
   end

endmodule

`default_nettype wire

// ==== source/rv_serial_core.sv ====
`default_nettype none

module rv_serial_core #(
   parameter rv_serial_pkg::word_t RESET_PC = '0
) (
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire rv_serial_pkg::word_t i_ibus_rdt,
   input  wire                       i_ibus_ack,
   input  wire                       i_dbus_ack,
   output wire rv_serial_pkg::word_t o_ibus_adr,
   output wire                       o_ibus_cyc,
   output wire rv_serial_pkg::word_t o_dbus_adr,
   output wire rv_serial_pkg::word_t o_dbus_dat,
   output wire                       o_dbus_cyc
);

   wire rs1_bit;
   wire rs2_bit;
   wire rd_bit;

   cnt_if cnt ();
   dec_if dec ();

   core_state state_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .dec        (dec.user),
      .cnt        (cnt.state),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc)
   );

   instr_decode decode_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .cnt        (cnt.sink),
      .dec        (dec.dec)
   );

   serial_regfile regfile_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_rd_bit  (rd_bit),
      .cnt       (cnt.sink),
      .dec       (dec.user),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serial_alu alu_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .cnt       (cnt.sink),
      .dec       (dec.user),
      .o_rd_bit  (rd_bit)
   );

   store_unit store_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .cnt        (cnt.sink),
      .dec        (dec.user),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

   pc_ctrl #(
      .RESET_PC (RESET_PC)
   ) pc_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .cnt     (cnt.sink),
      .o_pc    (o_ibus_adr)
   );

endmodule

`default_nettype wire

// ==== test/store_checker.sv ====
`default_nettype none

module store_checker (
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire rv_serial_pkg::word_t i_ibus_adr,
   input  wire rv_serial_pkg::word_t i_ibus_rdt,
   input  wire                       i_ibus_cyc,
   input  wire                       i_ibus_ack,
   input  wire rv_serial_pkg::word_t i_dbus_adr,
   input  wire rv_serial_pkg::word_t i_dbus_dat,
   input  wire                       i_dbus_cyc,
   input  wire                       i_dbus_ack,
   input  wire rv_serial_pkg::word_t i_exp_adr,
   input  wire rv_serial_pkg::word_t i_exp_dat,
   input  wire rv_serial_pkg::word_t i_exp_count,
   output int                        o_errors,
   output int                        o_stores
);
   timeunit 1ns;
   timeprecision 1ps;
   import rv_serial_pkg::*;

   word_t exp_fetch;
   word_t held_ibus_adr;
   word_t held_dbus_adr;
   word_t held_dbus_dat;
   logic  ibus_wait;
   logic  dbus_wait;
   logic  last_was_sw;

   task automatic report_mismatch(input string name, input word_t exp, input word_t act);
      $display("error %s: expected %h actual %h", name, exp, act);
      o_errors++;
   endtask

   initial begin
      o_errors    = 0;
      o_stores    = 0;
      exp_fetch   = '0;
      ibus_wait   = 1'b0;
      dbus_wait   = 1'b0;
      last_was_sw = 1'b0;
   end

   always @(posedge clk) begin
      if (!i_rst_n) begin
         if (i_ibus_cyc || i_dbus_cyc) begin
            $display("A bus cycle was active while reset was held");
            o_errors++;
         end
      end else begin
         // Request must not move while the bus holds off
         if (ibus_wait && i_ibus_cyc && (i_ibus_adr != held_ibus_adr))
            report_mismatch("ibus_stable_adr", held_ibus_adr, i_ibus_adr);
         if (dbus_wait && i_dbus_cyc && (i_dbus_adr != held_dbus_adr))
            report_mismatch("dbus_stable_adr", held_dbus_adr, i_dbus_adr);
         if (dbus_wait && i_dbus_cyc && (i_dbus_dat != held_dbus_dat))
            report_mismatch("dbus_stable_dat", held_dbus_dat, i_dbus_dat);

         if (i_ibus_cyc && i_ibus_ack) begin
            if (i_ibus_adr != exp_fetch)
               report_mismatch("fetch_adr", exp_fetch, i_ibus_adr);
            exp_fetch   = exp_fetch + 32'd4;
            // SW is opcode 0100011 with funct3 010
            last_was_sw = (i_ibus_rdt[6:0] == 7'b0100011) && (i_ibus_rdt[14:12] == 3'b010);
         end

         if (i_dbus_cyc && !last_was_sw) begin
            $display("Data bus cycle started without a store instruction");
            o_errors++;
         end

         if (i_dbus_cyc && i_dbus_ack) begin
            if (o_stores >= int'(i_exp_count)) begin
               $display("More stores than the %0d expected", i_exp_count);
               o_errors++;
            end else begin
               if (i_dbus_adr != i_exp_adr)
                  report_mismatch($sformatf("store%0d_adr", o_stores), i_exp_adr, i_dbus_adr);
               if (i_dbus_dat != i_exp_dat)
                  report_mismatch($sformatf("store%0d_dat", o_stores), i_exp_dat, i_dbus_dat);
            end
            o_stores++;
         end

         ibus_wait     = i_ibus_cyc && !i_ibus_ack;
         dbus_wait     = i_dbus_cyc && !i_dbus_ack;
         held_ibus_adr = i_ibus_adr;
         held_dbus_adr = i_dbus_adr;
         held_dbus_dat = i_dbus_dat;
      end
   end

endmodule

`default_nettype wire

// ==== test/tb_rv_serial_core.sv ====
`default_nettype none

module tb_rv_serial_core;
   timeunit 1ns;
   timeprecision 1ps;
   import rv_serial_pkg::*;

   localparam word_t NOP        = 32'h0000_0013;
   localparam int    IDLE_LIMIT = 5000;
   localparam int    RUN_LIMIT  = 20000;

   logic  clk;
   logic  i_rst_n;
   word_t i_ibus_rdt;
   logic  i_ibus_ack;
   logic  i_dbus_ack;
   word_t o_ibus_adr;
   logic  o_ibus_cyc;
   word_t o_dbus_adr;
   word_t o_dbus_dat;
   logic  o_dbus_cyc;

   word_t mem [0:127];
   word_t exp_count;
   word_t exp_adr;
   word_t exp_dat;
   int    errors;
   int    stores;
   int    hung;
   int    seed;

   rv_serial_core #(
      .RESET_PC (32'h0)
   ) rv_serial_core_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_cyc (o_dbus_cyc)
   );

   // Expected pairs start right after the count word
   assign exp_adr = mem[7'(65 + 2 * stores)];
   assign exp_dat = mem[7'(66 + 2 * stores)];

   store_checker checker_i (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ibus_adr  (o_ibus_adr),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_ibus_cyc  (o_ibus_cyc),
      .i_ibus_ack  (i_ibus_ack),
      .i_dbus_adr  (o_dbus_adr),
      .i_dbus_dat  (o_dbus_dat),
      .i_dbus_cyc  (o_dbus_cyc),
      .i_dbus_ack  (i_dbus_ack),
      .i_exp_adr   (exp_adr),
      .i_exp_dat   (exp_dat),
      .i_exp_count (exp_count),
      .o_errors    (errors),
      .o_stores    (stores)
   );

   function automatic word_t fetch_word(input word_t adr);
      // Beyond the program region the core only sees no-ops
      if (adr < 32'd256 && !$isunknown(mem[{1'b0, adr[7:2]}]))
         return mem[{1'b0, adr[7:2]}];
      return NOP;
   endfunction

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin : ibus_responder
      int waited;
      int delay;
      while (hung == 0) begin
         waited = 0;
         while (o_ibus_cyc !== 1'b1 && hung == 0) begin
            @(negedge clk);
            waited++;
            if (waited > IDLE_LIMIT) begin
               $display("Timeout waiting for an instruction fetch");
               hung++;
            end
         end
         if (hung == 0) begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            i_ibus_rdt = fetch_word(o_ibus_adr);
            i_ibus_ack = 1'b1;
            @(negedge clk);
            i_ibus_ack = 1'b0;
         end
      end
   end

   initial begin : dbus_responder
      int waited;
      int delay;
      while (hung == 0) begin
         waited = 0;
         while (o_dbus_cyc !== 1'b1 && hung == 0) begin
            @(negedge clk);
            waited++;
            if (waited > IDLE_LIMIT) begin
               $display("Timeout waiting for a data bus store");
               hung++;
            end
         end
         if (hung == 0) begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            i_dbus_ack = 1'b1;
            @(negedge clk);
            i_dbus_ack = 1'b0;
         end
      end
   end

   initial begin : main
      int   waited;
      logic data_ok;
      seed       = 37339;
      hung       = 0;
      i_rst_n    = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      $readmemh("test/rv_serial_testdata.txt", mem);
      exp_count = mem[64];
      data_ok   = !$isunknown(exp_count) && (exp_count != '0);
      if (!data_ok)
         $display("Test data file gave no expected store count");

      repeat (10) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;

      waited = 0;
      while (stores < int'(exp_count) && hung == 0) begin
         @(negedge clk);
         waited++;
         if (waited > RUN_LIMIT) begin
            $display("Timeout with %0d of %0d stores seen", stores, exp_count);
            hung++;
         end
      end
      // Room for any unexpected extra store to show up
      repeat (100) @(negedge clk);

      $display("Errors %0d, timeouts %0d, stores %0d of %0d", errors, hung, stores, exp_count);
      if (data_ok && errors == 0 && hung == 0 && stores == int'(exp_count)) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== rv_serial_core.f ====
source/rv_serial_pkg.sv
source/core_if.sv
source/core_state.sv
source/instr_decode.sv
source/serial_regfile.sv
source/serial_alu.sv
source/store_unit.sv
source/pc_ctrl.sv
source/rv_serial_core.sv
test/store_checker.sv
test/tb_rv_serial_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_serial_core \
   -f rv_serial_core.f -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -qx "TB PASSED" sim.log && exit 0 || exit 1

// ==== test/rv_serial_testdata.txt ====
// Words 0x00-0x3f: program, one instruction word each
// Word 0x40: expected store count, then pairs of store address and store data
12300093 FFB00113 0F00C193 00416213 0FF0F293 ABCDE337
002083B3 40110433 0030C4B3 0060E533 002375B3 00508013
0000000B 00202423 00302623 00402823 00502A23 00602C23
00702E23 02802023 02902223 02A02423 02B02623 FE00A023
@40
0000000B
00000008 FFFFFFFB
0000000C 000001D3
00000010 FFFFFFFF
00000014 00000023
00000018 ABCDE000
0000001C 0000011E
00000020 FFFFFED8
00000024 000000F0
00000028 ABCDE123
0000002C ABCDE000
00000103 00000000
